// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN        32
`define CPU_RESET_PC    32'h0000_0000
`define CPU_TRAP_VECTOR 32'h0000_0100
`define CPU_NOP         32'h0000_0013  // ADDI x0, x0, 0

`define CPU_OP_R      7'b0110011
`define CPU_OP_I      7'b0010011
`define CPU_OP_LOAD   7'b0000011
`define CPU_OP_STORE  7'b0100011
`define CPU_OP_BRANCH 7'b1100011
`define CPU_OP_SYSTEM 7'b1110011

`define CPU_F3_ADD   3'b000
`define CPU_F3_XOR   3'b100
`define CPU_F3_OR    3'b110
`define CPU_F3_AND   3'b111
`define CPU_F3_WORD  3'b010  // LW and SW
`define CPU_F3_BEQ   3'b000
`define CPU_F7_SUB   7'b0100000
`define CPU_F12_MRET 12'h302

`define CPU_FWD_NONE 2'd0
`define CPU_FWD_WB   2'd1
`define CPU_FWD_MEM  2'd2

`endif

// File: logic/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [4:0]           reg_addr_t;
  typedef logic [2:0]           alu_op_t;
  typedef logic [1:0]           fwd_sel_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;

  typedef enum logic [1:0] {
    IRQ_IDLE,
    IRQ_DRAIN1,
    IRQ_DRAIN2
  } irq_state_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    mret;
  } ctrl_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rd1;
    word_t     rd2;
    logic      valid;
    ctrl_t     ctrl;
  } dec_bundle_t;

  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_port_t;

  typedef struct packed {
    logic  branch_taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    reg_addr_t rs1_d;
    reg_addr_t rs2_d;
    reg_addr_t rs1_e;
    reg_addr_t rs2_e;
    reg_addr_t rd_e;
    logic      mem_read_e;
    reg_addr_t rd_m;
    logic      reg_write_m;
    reg_addr_t rd_w;
    logic      reg_write_w;
  } hazard_view_t;

  typedef struct packed {
    word_t pc;
    logic  valid;
  } ex_pc_t;

  typedef struct packed {
    logic trap_stages;
    logic trap_pc;
    logic stall_f;
    logic stall_d;
    logic stall_e;
    logic stall_m;
    logic flush_f;
    logic flush_d;
    logic flush_e;
    logic flush_m;
  } irq_req_t;

  typedef struct packed {
    logic stall_f;
    logic stall_d;
    logic stall_e;
    logic flush_d;
    logic flush_e;
    logic flush_m;
  } pipe_ctrl_t;

endpackage

`default_nettype wire

// File: logic/cpu_control.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_control
  import cpu_pkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl,
  output word_t imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    ctrl = '0;  // Anything not matched below leaves every write enable low
    imm  = {{20{instr[31]}}, instr[31:20]};
    case (opcode)
      `CPU_OP_R: begin
        ctrl.reg_write = 1'b1;
        case (funct3)
          `CPU_F3_ADD: ctrl.alu_op = (funct7 == `CPU_F7_SUB) ? ALU_SUB : ALU_ADD;
          `CPU_F3_XOR: ctrl.alu_op = ALU_XOR;
          `CPU_F3_OR:  ctrl.alu_op = ALU_OR;
          `CPU_F3_AND: ctrl.alu_op = ALU_AND;
          default:     ctrl.reg_write = 1'b0;
        endcase
      end
      `CPU_OP_I: begin
        ctrl.alu_src_imm = (funct3 == `CPU_F3_ADD);
        ctrl.reg_write   = (funct3 == `CPU_F3_ADD);  // ADDI only
      end
      `CPU_OP_LOAD: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = (funct3 == `CPU_F3_WORD);
        ctrl.mem_read    = (funct3 == `CPU_F3_WORD);
      end
      `CPU_OP_STORE: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = (funct3 == `CPU_F3_WORD);
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      `CPU_OP_BRANCH: begin
        ctrl.alu_op = ALU_SUB;
        ctrl.branch = (funct3 == `CPU_F3_BEQ);
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      `CPU_OP_SYSTEM: begin
        ctrl.mret = (instr[31:20] == `CPU_F12_MRET);
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/cpu_register_file.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_register_file
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2,
  input  wb_port_t  wb
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // A write in flight is handed straight to a reader of the same register
  assign rd1 = (ra1 == '0) ? '0 : (wb.we && wb.rd == ra1) ? wb.data : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (wb.we && wb.rd == ra2) ? wb.data : regs[ra2];

  a_x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (wb.we && wb.rd == '0) |=> (ra1 != '0 || rd1 == '0) && (ra2 != '0 || rd2 == '0))
    else $error("x0 read back nonzero after a write to it");

endmodule

`default_nettype wire

// File: logic/cpu_hazard_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_hazard_unit
  import cpu_pkg::*;
(
  input  hazard_view_t view,
  input  redirect_t    redir,
  input  irq_req_t     ireq,
  output fwd_sel_t     fwd_a,
  output fwd_sel_t     fwd_b,
  output pipe_ctrl_t   pctl
);

  logic load_use;

  // Memory stage holds the younger result so it is checked first
  function automatic fwd_sel_t pick_fwd(reg_addr_t rs, hazard_view_t v);
    fwd_sel_t sel;
    sel = `CPU_FWD_NONE;
    if (rs != '0 && v.reg_write_m && v.rd_m == rs) begin
      sel = `CPU_FWD_MEM;
    end else if (rs != '0 && v.reg_write_w && v.rd_w == rs) begin
      sel = `CPU_FWD_WB;
    end
    return sel;
  endfunction

  assign fwd_a = pick_fwd(view.rs1_e, view);
  assign fwd_b = pick_fwd(view.rs2_e, view);

  assign load_use = view.mem_read_e && view.rd_e != '0 &&
                    (view.rd_e == view.rs1_d || view.rd_e == view.rs2_d);

  always_comb begin
    if (ireq.trap_stages) begin  // The trap sequence owns the pipeline
      pctl.stall_f = ireq.stall_f;
      pctl.stall_d = ireq.stall_d;
      pctl.stall_e = ireq.stall_e;
      pctl.flush_d = ireq.flush_d;
      pctl.flush_e = ireq.flush_e;
      pctl.flush_m = ireq.flush_m;
    end else begin
      pctl.stall_f = load_use;
      pctl.stall_d = load_use;
      pctl.stall_e = 1'b0;
      pctl.flush_d = redir.branch_taken;
      pctl.flush_e = load_use || redir.branch_taken;
      pctl.flush_m = 1'b0;
    end
  end

  a_no_fwd_x0: assert final (!((fwd_a != `CPU_FWD_NONE && view.rs1_e == '0) ||
                               (fwd_b != `CPU_FWD_NONE && view.rs2_e == '0)))
    else $error("operand forwarded for source x0");

endmodule

`default_nettype wire

// File: logic/cpu_irq_control.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_irq_control
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     irq,
  output irq_req_t ireq,
  output logic     trap_pc
);

  irq_state_t state_q;
  irq_state_t state_next;
  logic       irq_q;
  logic       pending_q;
  logic       ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q     <= 1'b0;
      pending_q <= 1'b0;
      state_q   <= IRQ_IDLE;
    end else begin
      irq_q   <= irq;
      state_q <= state_next;
      if (irq && !irq_q) begin
        pending_q <= 1'b1;  // A new edge is never lost to an ack
      end else if (ack) begin
        pending_q <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Older work drains through M and W while F, D and E wait
  always_comb begin
    ireq       = '0;
    ack        = 1'b0;
    state_next = state_q;
    case (state_q)
      IRQ_IDLE: begin
        if (pending_q) begin
          ireq.trap_stages = 1'b1;
          ireq.stall_f     = 1'b1;
          ireq.stall_d     = 1'b1;
          ireq.stall_e     = 1'b1;
          ireq.flush_m     = 1'b1;
          ack              = 1'b1;
          state_next       = IRQ_DRAIN1;
        end
      end
      IRQ_DRAIN1: begin
        ireq.trap_stages = 1'b1;
        ireq.stall_f     = 1'b1;
        ireq.stall_d     = 1'b1;
        ireq.stall_e     = 1'b1;
        ireq.flush_m     = 1'b1;
        state_next       = IRQ_DRAIN2;
      end
      IRQ_DRAIN2: begin
        ireq.trap_stages = 1'b1;
        ireq.stall_f     = 1'b1;
        ireq.stall_d     = 1'b1;
        ireq.stall_e     = 1'b1;
        ireq.flush_d     = 1'b1;  // Flush wins over the stall
        ireq.flush_e     = 1'b1;
        ireq.flush_m     = 1'b1;
        ireq.trap_pc     = 1'b1;
        state_next       = IRQ_IDLE;
      end
      default: state_next = IRQ_IDLE;
    endcase
  end

  assign trap_pc = ireq.trap_pc;

  a_trap_pc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    trap_pc |=> !trap_pc)
    else $error("trap_pc held for two cycles");

endmodule

`default_nettype wire

// File: logic/cpu_front_end.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_front_end
  import cpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  output word_t           instr_addr,
  input  word_t           instr_data,
  input  pipe_ctrl_t      pctl,
  input  redirect_t       redir,
  input  ex_pc_t          ex_pc,
  input  logic            trap_pc,
  input  wb_port_t        wb,
  output dec_bundle_t     dec,
  output reg_addr_t [1:0] view_d  // [0] is rs1, [1] is rs2
);

  word_t pc_q;
  word_t pc_next;
  word_t mepc_q;
  word_t pc_d;
  word_t instr_d;
  logic  valid_d;
  logic  mret_go;
  ctrl_t ctrl_raw;
  word_t imm_d;
  word_t rd1_d;
  word_t rd2_d;

  // ------------------------------------------------------------------------
  // Fetch
  assign mret_go = valid_d && ctrl_raw.mret && !pctl.stall_d && !pctl.flush_d;
  assign pc_next = mret_go ? mepc_q : redir.branch_taken ? redir.target : pc_q + 32'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `CPU_RESET_PC;
    end else if (trap_pc) begin
      pc_q <= `CPU_TRAP_VECTOR;
    end else if (!pctl.stall_f) begin
      pc_q <= pc_next;
    end
  end

  // Return address is the oldest instruction that has not finished
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q <= `CPU_RESET_PC;
    end else if (trap_pc) begin
      mepc_q <= ex_pc.valid ? ex_pc.pc : valid_d ? pc_d : pc_q;
    end
  end

  assign instr_addr = pc_q;

  // ------------------------------------------------------------------------
  // Decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_d    <= `CPU_RESET_PC;
      instr_d <= `CPU_NOP;
      valid_d <= 1'b0;
    end else if (pctl.flush_d || mret_go) begin
      instr_d <= `CPU_NOP;
      valid_d <= 1'b0;
    end else if (!pctl.stall_d) begin
      pc_d    <= pc_q;
      instr_d <= instr_data;
      valid_d <= 1'b1;
    end
  end

  cpu_control u_control (
    .instr (instr_d),
    .ctrl  (ctrl_raw),
    .imm   (imm_d)
  );

  cpu_register_file u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (instr_d[19:15]),
    .ra2   (instr_d[24:20]),
    .rd1   (rd1_d),
    .rd2   (rd2_d),
    .wb    (wb)
  );

  always_comb begin
    dec.pc    = pc_d;
    dec.rs1   = instr_d[19:15];
    dec.rs2   = instr_d[24:20];
    dec.rd    = instr_d[11:7];
    dec.imm   = imm_d;
    dec.rd1   = rd1_d;
    dec.rd2   = rd2_d;
    dec.valid = valid_d;
    dec.ctrl  = valid_d ? ctrl_raw : '0;  // Bubbles carry no write enables
  end

  assign view_d[0] = instr_d[19:15];
  assign view_d[1] = instr_d[24:20];

endmodule

`default_nettype wire

// File: logic/cpu_back_end.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_back_end
  import cpu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dec_bundle_t  dec,
  input  pipe_ctrl_t   pctl,
  input  fwd_sel_t     fwd_a,
  input  fwd_sel_t     fwd_b,
  output hazard_view_t view,
  output ex_pc_t       ex_pc,
  output redirect_t    redir,
  output wb_port_t     wb,
  output word_t        data_addr,
  output word_t        data_wdata,
  output logic         data_we,
  input  word_t        data_rdata
);

  localparam dec_bundle_t EX_BUBBLE = '0;

  dec_bundle_t ex_q;
  word_t       op_a;
  word_t       op_b;
  word_t       alu_b;
  word_t       alu_y;
  logic        reg_write_m;
  logic        mem_read_m;
  logic        mem_write_m;
  reg_addr_t   rd_m;
  word_t       alu_m;
  word_t       store_m;
  logic        reg_write_w;
  logic        mem_read_w;
  reg_addr_t   rd_w;
  word_t       alu_w;
  word_t       load_w;
  word_t       wb_data;

  function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                     word_t wb_val);
    case (sel)
      `CPU_FWD_MEM: return mem_val;
      `CPU_FWD_WB:  return wb_val;
      default:      return reg_val;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Execute
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_q <= EX_BUBBLE;
    end else if (pctl.flush_e) begin
      ex_q <= EX_BUBBLE;
    end else if (!pctl.stall_e) begin
      ex_q <= dec;
    end
  end

  assign op_a  = fwd_pick(fwd_a, ex_q.rd1, alu_m, wb_data);
  assign op_b  = fwd_pick(fwd_b, ex_q.rd2, alu_m, wb_data);
  assign alu_b = ex_q.ctrl.alu_src_imm ? ex_q.imm : op_b;

  always_comb begin
    case (ex_q.ctrl.alu_op)
      ALU_SUB: alu_y = op_a - alu_b;
      ALU_AND: alu_y = op_a & alu_b;
      ALU_OR:  alu_y = op_a | alu_b;
      ALU_XOR: alu_y = op_a ^ alu_b;
      default: alu_y = op_a + alu_b;
    endcase
  end

  assign redir.branch_taken = ex_q.ctrl.branch && (op_a == op_b);
  assign redir.target       = ex_q.pc + ex_q.imm;
  assign ex_pc.pc           = ex_q.pc;
  assign ex_pc.valid        = ex_q.valid;

  // ------------------------------------------------------------------------
  // Memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_write_m <= 1'b0;
      mem_read_m  <= 1'b0;
      mem_write_m <= 1'b0;
    end else if (pctl.flush_m) begin
      reg_write_m <= 1'b0;
      mem_read_m  <= 1'b0;
      mem_write_m <= 1'b0;
    end else begin
      reg_write_m <= ex_q.ctrl.reg_write;
      mem_read_m  <= ex_q.ctrl.mem_read;
      mem_write_m <= ex_q.ctrl.mem_write;
    end
  end

  always_ff @(posedge clk) begin
    rd_m    <= ex_q.rd;
    alu_m   <= alu_y;
    store_m <= op_b;
  end

  assign data_addr  = alu_m;
  assign data_wdata = store_m;
  assign data_we    = mem_write_m;

  // ------------------------------------------------------------------------
  // Writeback
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_write_w <= 1'b0;
      mem_read_w  <= 1'b0;
    end else begin
      reg_write_w <= reg_write_m;
      mem_read_w  <= mem_read_m;
    end
  end

  always_ff @(posedge clk) begin
    rd_w   <= rd_m;
    alu_w  <= alu_m;
    load_w <= data_rdata;
  end

  assign wb_data = mem_read_w ? load_w : alu_w;
  assign wb.we   = reg_write_w;
  assign wb.rd   = rd_w;
  assign wb.data = wb_data;

  always_comb begin
    view.rs1_d       = '0;  // Decode sources come from the front end
    view.rs2_d       = '0;
    view.rs1_e       = ex_q.rs1;
    view.rs2_e       = ex_q.rs2;
    view.rd_e        = ex_q.rd;
    view.mem_read_e  = ex_q.ctrl.mem_read;
    view.rd_m        = rd_m;
    view.reg_write_m = reg_write_m;
    view.rd_w        = rd_w;
    view.reg_write_w = reg_write_w;
  end

endmodule

`default_nettype wire

// File: logic/pipelined_cpu.sv
`default_nettype none
`timescale 1ns/1ps

module pipelined_cpu
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr_data,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata,
  input  logic  irq
);

  dec_bundle_t     dec;
  wb_port_t        wb;
  redirect_t       redir;
  ex_pc_t          ex_pc;
  hazard_view_t    be_view;
  hazard_view_t    view;
  reg_addr_t [1:0] view_d;
  irq_req_t        ireq;
  pipe_ctrl_t      pctl;
  fwd_sel_t        fwd_a;
  fwd_sel_t        fwd_b;
  logic            trap_pc;

  cpu_front_end u_front (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .pctl       (pctl),
    .redir      (redir),
    .ex_pc      (ex_pc),
    .trap_pc    (trap_pc),
    .wb         (wb),
    .dec        (dec),
    .view_d     (view_d)
  );

  cpu_back_end u_back (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (dec),
    .pctl       (pctl),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .view       (be_view),
    .ex_pc      (ex_pc),
    .redir      (redir),
    .wb         (wb),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_rdata (data_rdata)
  );

  // Hazard view is the back end's fields plus the decode sources
  always_comb begin
    view       = be_view;
    view.rs1_d = view_d[0];
    view.rs2_d = view_d[1];
  end

  cpu_hazard_unit u_hazard (
    .view  (view),
    .redir (redir),
    .ireq  (ireq),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b),
    .pctl  (pctl)
  );

  cpu_irq_control u_irq (
    .clk     (clk),
    .rst_n   (rst_n),
    .irq     (irq),
    .ireq    (ireq),
    .trap_pc (trap_pc)
  );

endmodule

`default_nettype wire

// File: sim/tb_pipelined_cpu.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_pipelined_cpu
  import cpu_pkg::*;
();

  localparam int    TIMEOUT     = 200;
  localparam int    TRAP_LIMIT  = 8;
  localparam int    IRQ_AT      = 12;  // Table entry before which irq is pulsed
  localparam word_t MARKER_ADDR = 32'h0000_00FC;
  localparam word_t MARKER_VAL  = 32'h0000_05A5;
  localparam word_t LOAD_BASE   = 32'h0000_00C0;
  localparam int    K_ADD       = 0;
  localparam int    K_SUB       = 1;
  localparam int    K_AND       = 2;
  localparam int    K_OR        = 3;
  localparam int    K_XOR       = 4;

  logic  clk;
  logic  rst_n;
  logic  irq;
  word_t instr_addr;
  word_t instr_data;
  word_t data_addr;
  word_t data_wdata;
  logic  data_we;
  word_t data_rdata;

  word_t imem [0:127];
  word_t dmem [0:63];
  word_t model [0:31];  // Register values as the program defines them
  word_t exp_addr [$];
  word_t exp_data [$];
  int    exp_test [$];
  word_t seen_addr [$];
  word_t seen_data [$];

  logic [31:0] seed         = 32'd47;
  int          pc_word      = 0;
  int          skip         = 0;
  int          n_store      = 0;
  int          cur_test     = 0;
  int          cycle        = 0;
  int          errors       = 0;
  int          n_checks     = 0;
  int          n_tests      = 0;
  int          n_failed     = 0;
  int          test_base    = 0;
  int          marker_count = 0;
  word_t       marker_data  = '0;
  logic        trap_seen    = 1'b0;
  int          trap_cycle   = 0;
  int          irq_cycle    = 0;

  pipelined_cpu uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_rdata (data_rdata),
    .irq        (irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign instr_data = imem[instr_addr[8:2]];
  assign data_rdata = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (data_we) begin
      dmem[data_addr[7:2]] <= data_wdata;
    end
  end

  // Bus is sampled mid-cycle where it is stable
  always @(negedge clk) begin
    if (rst_n && data_we) begin
      if (data_addr == MARKER_ADDR) begin
        marker_count++;
        marker_data = data_wdata;
      end else begin
        seen_addr.push_back(data_addr);
        seen_data.push_back(data_wdata);
      end
    end
    if (rst_n && !trap_seen && instr_addr == `CPU_TRAP_VECTOR) begin
      trap_seen  = 1'b1;
      trap_cycle = cycle;
    end
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t fill_word(input logic [5:0] idx);
    return 32'hC3A5_0000 ^ ({26'd0, idx} * 32'h0101_0101) ^ {idx, 26'd0};
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset state";
      1:       return "ALU on random immediates";
      2:       return "forwarding chain and x0";
      3:       return "load-use stall";
      4:       return "taken BEQ skips stores";
      default: return "interrupt trap and return";
    endcase
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input int t);
    n_tests++;
    if (errors == test_base) begin
      $display("Test %0d, %s: ok", t, test_name(t));
    end else begin
      n_failed++;
      $display("Test %0d, %s: %0d errors", t, test_name(t), errors - test_base);
    end
    test_base = errors;
  endtask

  // --------------------------------------------------------------------------
  // Program builder
  task automatic emit(input word_t instr, output logic live);
    imem[pc_word] = instr;
    pc_word = pc_word + 1;
    live = (skip == 0);  // Instructions a taken branch jumps over never run
    if (skip > 0) begin
      skip = skip - 1;
    end
  endtask

  task automatic set_reg(input logic live, input reg_addr_t rd, input word_t value);
    if (live && rd != 5'd0) begin
      model[rd] = value;
    end
  endtask

  task automatic op_addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    logic live;
    emit({imm, rs1, 3'b000, rd, `CPU_OP_I}, live);
    set_reg(live, rd, model[rs1] + {{20{imm[11]}}, imm});
  endtask

  task automatic rand_addi(input reg_addr_t rd, input reg_addr_t rs1);
    seed = lcg(seed);
    op_addi(rd, rs1, seed[27:16]);
  endtask

  task automatic op_rr(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
                       input reg_addr_t rs2);
    logic       live;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      y;
    case (kind)
      K_ADD:   y = model[rs1] + model[rs2];
      K_SUB:   y = model[rs1] - model[rs2];
      K_AND:   y = model[rs1] & model[rs2];
      K_OR:    y = model[rs1] | model[rs2];
      default: y = model[rs1] ^ model[rs2];
    endcase
    f3 = (kind == K_AND) ? 3'b111 : (kind == K_OR) ? 3'b110 :
         (kind == K_XOR) ? 3'b100 : 3'b000;
    f7 = (kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    emit({f7, rs2, rs1, f3, rd, `CPU_OP_R}, live);
    set_reg(live, rd, y);
  endtask

  task automatic op_lw(input reg_addr_t rd, input int slot);
    logic  live;
    word_t addr;
    addr = LOAD_BASE + 32'(4 * slot);
    emit({addr[11:0], 5'd0, 3'b010, rd, `CPU_OP_LOAD}, live);
    set_reg(live, rd, fill_word(addr[7:2]));
  endtask

  // Each store gets its own address, so a wrong-path store shows up as a bad address
  task automatic op_sw(input reg_addr_t rs2);
    logic  live;
    word_t addr;
    addr = 32'(4 * n_store);
    n_store = n_store + 1;
    emit({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], `CPU_OP_STORE}, live);
    if (live) begin
      exp_addr.push_back(addr);
      exp_data.push_back(model[rs2]);
      exp_test.push_back(cur_test);
    end
  endtask

  task automatic op_beq(input reg_addr_t rs1, input reg_addr_t rs2, input int nskip);
    logic        live;
    logic [12:0] off;
    off = 13'(4 * (nskip + 1));
    emit({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], `CPU_OP_BRANCH}, live);
    if (live && model[rs1] == model[rs2]) begin
      skip = nskip;
    end
  endtask

  task automatic build_program();
    int   i;
    int   tv;
    logic live;
    for (i = 0; i < 128; i++) begin
      imem[i] = `CPU_NOP;
    end
    for (i = 0; i < 64; i++) begin
      dmem[i] = fill_word(6'(i));
    end
    for (i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    cur_test = 1;
    rand_addi(1, 0);
    op_sw(1);
    rand_addi(2, 0);
    op_sw(2);
    op_rr(K_ADD, 3, 1, 2);
    op_sw(3);
    op_rr(K_SUB, 4, 1, 2);
    op_sw(4);
    op_rr(K_AND, 5, 1, 2);
    op_sw(5);
    op_rr(K_OR, 6, 1, 2);
    op_sw(6);
    op_rr(K_XOR, 7, 1, 2);
    op_sw(7);
    cur_test = 2;
    rand_addi(8, 1);
    op_rr(K_ADD, 9, 8, 8);
    op_rr(K_SUB, 10, 9, 8);
    op_sw(10);
    op_addi(0, 9, 12'h005);  // Result must not reach x0 readers
    op_rr(K_ADD, 12, 0, 10);
    op_sw(12);
    op_sw(0);
    cur_test = 3;
    op_lw(13, 0);
    op_rr(K_ADD, 14, 13, 1);
    op_sw(14);
    op_lw(15, 1);
    op_sw(15);
    cur_test = 4;
    op_beq(1, 1, 2);
    op_sw(2);
    op_sw(3);
    op_sw(4);
    op_beq(1, 2, 1);
    op_sw(5);
    op_sw(6);
    cur_test = 5;
    for (i = 16; i < 24; i++) begin
      rand_addi(5'(i), 0);
      op_sw(5'(i));
    end
    emit({7'd0, 5'd0, 5'd0, 3'b000, 5'd0, `CPU_OP_BRANCH}, live);  // Park on itself
    tv = `CPU_TRAP_VECTOR / 4;
    imem[tv]     = {MARKER_VAL[11:0], 5'd0, 3'b000, 5'd31, `CPU_OP_I};
    imem[tv + 1] = {MARKER_ADDR[11:5], 5'd31, 5'd0, 3'b010, MARKER_ADDR[4:0], `CPU_OP_STORE};
    imem[tv + 2] = {`CPU_F12_MRET, 5'd0, 3'b000, 5'd0, `CPU_OP_SYSTEM};
  endtask

  task automatic next_store(output word_t addr, output word_t data, output logic ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < TIMEOUT) begin
      if (seen_addr.size() > 0) begin
        addr = seen_addr.pop_front();
        data = seen_data.pop_front();
        ok = 1'b1;
      end else begin
        @(posedge clk);
        waited++;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  initial begin
    int    i;
    int    waited;
    logic  ok;
    logic  timed_out;
    word_t addr;
    word_t data;
    rst_n     = 1'b0;
    irq       = 1'b0;
    timed_out = 1'b0;
    build_program();

    repeat (2) @(posedge clk);
    @(negedge clk);
    check("instr_addr", instr_addr, `CPU_RESET_PC);
    check("data_we", {31'd0, data_we}, 32'd0);
    @(posedge clk);
    rst_n <= 1'b1;
    report_test(0);

    for (i = 0; i < exp_addr.size(); i++) begin
      if (i == IRQ_AT) begin
        @(posedge clk);
        irq <= 1'b1;
        irq_cycle = cycle;
        @(posedge clk);
        irq <= 1'b0;
      end
      next_store(addr, data, ok);
      if (!ok) begin
        $display("Timeout: store %0d of test %0d never appeared on the data bus",
                 i, exp_test[i]);
        errors++;
        report_test(exp_test[i]);
        timed_out = 1'b1;
        break;
      end
      check("data_addr", addr, exp_addr[i]);
      check("data_wdata", data, exp_data[i]);
      if (i + 1 < exp_addr.size() && exp_test[i + 1] != exp_test[i]) begin
        report_test(exp_test[i]);
      end
    end

    if (!timed_out) begin
      waited = 0;
      while ((!trap_seen || marker_count == 0) && waited < TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (!trap_seen) begin
        $display("The interrupt never brought instr_addr to the trap vector");
        errors++;
      end else if (trap_cycle - irq_cycle > TRAP_LIMIT) begin
        $display("The trap vector was reached %0d cycles after irq, which is too late",
                 trap_cycle - irq_cycle);
        errors++;
      end
      check("handler store count", 32'(marker_count), 32'd1);
      check("handler data_wdata", marker_data, MARKER_VAL);
      check("extra store count", 32'(seen_addr.size()), 32'd0);
      report_test(5);
    end

    $display("Tests run %0d, failed %0d; checks %0d, errors %0d",
             n_tests, n_failed, n_checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
logic/cpu_pkg.sv
logic/cpu_control.sv
logic/cpu_register_file.sv
logic/cpu_hazard_unit.sv
logic/cpu_irq_control.sv
logic/cpu_front_end.sv
logic/cpu_back_end.sv
logic/pipelined_cpu.sv
sim/tb_pipelined_cpu.sv
